/* src/soc_pkg.sv */
package soc_pkg;

    // Bus widths
    localparam int unsigned AXI_ADDR_WIDTH = 32;
    localparam int unsigned AXI_DATA_WIDTH = 32;
    localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8; // One strobe per byte

    // Response codes, only the two the system produces
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_DECERR = 2'd3
    } resp_t;

    // Address map
    localparam logic [AXI_ADDR_WIDTH-1:0] SRAM_BASE  = 32'h8000_0000;
    localparam logic [AXI_ADDR_WIDTH-1:0] SRAM_MASK  = 32'hF000_0000; // 256 MB window
    localparam logic [AXI_ADDR_WIDTH-1:0] CLINT_BASE = 32'hA000_0048;
    localparam logic [AXI_ADDR_WIDTH-1:0] CLINT_MASK = 32'hFFFF_FFF8; // mtime lo and hi
    localparam logic [AXI_ADDR_WIDTH-1:0] UART_BASE  = 32'hA000_03F8;
    localparam logic [AXI_ADDR_WIDTH-1:0] UART_MASK  = 32'hFFFF_FFFF; // Single TX word

    // Manager to subordinate
    typedef struct packed {
        logic [AXI_ADDR_WIDTH-1:0] aw_addr;
        logic                      aw_valid;
        logic [AXI_DATA_WIDTH-1:0] w_data;
        logic [AXI_STRB_WIDTH-1:0] w_strb;
        logic                      w_valid;
        logic                      b_ready;
        logic [AXI_ADDR_WIDTH-1:0] ar_addr;
        logic                      ar_valid;
        logic                      r_ready;
    } axi_req_t;

    // Subordinate to manager
    typedef struct packed {
        logic                      aw_ready;
        logic                      w_ready;
        resp_t                     b_resp;
        logic                      b_valid;
        logic                      ar_ready;
        logic [AXI_DATA_WIDTH-1:0] r_data;
        resp_t                     r_resp;
        logic                      r_valid;
    } axi_rsp_t;

    // Address hits a device window
    function automatic logic addr_hit(input logic [AXI_ADDR_WIDTH-1:0] addr,
                                      input logic [AXI_ADDR_WIDTH-1:0] base,
                                      input logic [AXI_ADDR_WIDTH-1:0] mask);
        return (addr & mask) == (base & mask);
    endfunction

endpackage

/* src/axi_lite_xbar.sv */
`timescale 1ns/1ps

module axi_lite_xbar (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::axi_req_t fetch_req,
    input  soc_pkg::axi_req_t lsu_req,
    output soc_pkg::axi_rsp_t fetch_rsp,
    output soc_pkg::axi_rsp_t lsu_rsp,
    output soc_pkg::axi_req_t sram_req,
    input  soc_pkg::axi_rsp_t sram_rsp,
    output soc_pkg::axi_req_t clint_req,
    input  soc_pkg::axi_rsp_t clint_rsp,
    output soc_pkg::axi_req_t uart_req,
    input  soc_pkg::axi_rsp_t uart_rsp
);

    typedef enum logic [1:0] {ST_IDLE, ST_WR, ST_RD} state_t;
    typedef enum logic {MGR_LSU, MGR_FETCH} mgr_t;
    typedef enum logic [1:0] {TGT_SRAM, TGT_CLINT, TGT_UART, TGT_NONE} tgt_t;

    state_t state;                                   // One transaction in flight
    mgr_t   grant;                                   // Owner of the bus
    tgt_t   target;                                  // Decoded device, latched at grant
    logic   err_bvalid;                              // Own DECERR write response
    logic   err_rvalid;                              // Own DECERR read response

    logic                                pick_valid; // Some request waiting in idle
    mgr_t                                pick_mgr;
    logic                                pick_wr;
    logic [soc_pkg::AXI_ADDR_WIDTH-1:0]  pick_addr;
    soc_pkg::axi_req_t                   sel_req;    // Granted manager, raw
    soc_pkg::axi_req_t                   fwd_req;    // Channels masked by state
    soc_pkg::axi_rsp_t                   err_rsp;
    soc_pkg::axi_rsp_t                   tgt_rsp;
    soc_pkg::axi_rsp_t                   mgr_rsp;    // Response masked by state
    logic                                b_done;
    logic                                r_done;

    function automatic tgt_t decode(input logic [soc_pkg::AXI_ADDR_WIDTH-1:0] addr);
        if (soc_pkg::addr_hit(addr, soc_pkg::SRAM_BASE, soc_pkg::SRAM_MASK)) begin
            return TGT_SRAM;
        end
        if (soc_pkg::addr_hit(addr, soc_pkg::CLINT_BASE, soc_pkg::CLINT_MASK)) begin
            return TGT_CLINT;
        end
        if (soc_pkg::addr_hit(addr, soc_pkg::UART_BASE, soc_pkg::UART_MASK)) begin
            return TGT_UART;
        end
        return TGT_NONE;                             // Unmapped hole
    endfunction

    // Fixed priority: lsu wr, lsu rd, fetch wr, fetch rd
    always_comb begin
        pick_valid = 1'b1;
        pick_mgr   = MGR_LSU;
        pick_wr    = 1'b1;
        pick_addr  = lsu_req.aw_addr;
        if (lsu_req.aw_valid && lsu_req.w_valid) begin
            pick_addr = lsu_req.aw_addr;             // AW and W must come together
        end else if (lsu_req.ar_valid) begin
            pick_wr   = 1'b0;
            pick_addr = lsu_req.ar_addr;
        end else if (fetch_req.aw_valid && fetch_req.w_valid) begin
            pick_mgr  = MGR_FETCH;
            pick_addr = fetch_req.aw_addr;
        end else if (fetch_req.ar_valid) begin
            pick_mgr  = MGR_FETCH;
            pick_wr   = 1'b0;
            pick_addr = fetch_req.ar_addr;
        end else begin
            pick_valid = 1'b0;
        end
    end

    always_comb begin
        sel_req          = (grant == MGR_LSU) ? lsu_req : fetch_req;
        fwd_req          = sel_req;
        fwd_req.aw_valid = sel_req.aw_valid && (state == ST_WR); // Only the granted channel
        fwd_req.w_valid  = sel_req.w_valid && (state == ST_WR);
        fwd_req.b_ready  = sel_req.b_ready && (state == ST_WR);
        fwd_req.ar_valid = sel_req.ar_valid && (state == ST_RD);
        fwd_req.r_ready  = sel_req.r_ready && (state == ST_RD);
    end

    assign sram_req  = (target == TGT_SRAM)  ? fwd_req : soc_pkg::axi_req_t'('0);
    assign clint_req = (target == TGT_CLINT) ? fwd_req : soc_pkg::axi_req_t'('0);
    assign uart_req  = (target == TGT_UART)  ? fwd_req : soc_pkg::axi_req_t'('0);

    // Decode-error responder, same one-cycle timing as a device
    always_comb begin
        err_rsp          = '0;
        err_rsp.aw_ready = fwd_req.aw_valid && fwd_req.w_valid && !err_bvalid;
        err_rsp.w_ready  = err_rsp.aw_ready;
        err_rsp.b_resp   = soc_pkg::RESP_DECERR;
        err_rsp.b_valid  = err_bvalid;
        err_rsp.ar_ready = fwd_req.ar_valid && !err_rvalid;
        err_rsp.r_resp   = soc_pkg::RESP_DECERR;     // r_data stays zero
        err_rsp.r_valid  = err_rvalid;
    end

    always_comb begin
        case (target)
            TGT_SRAM:  tgt_rsp = sram_rsp;
            TGT_CLINT: tgt_rsp = clint_rsp;
            TGT_UART:  tgt_rsp = uart_rsp;
            default:   tgt_rsp = err_rsp;
        endcase
        mgr_rsp = '0;
        if (state == ST_WR) begin
            mgr_rsp.aw_ready = tgt_rsp.aw_ready;
            mgr_rsp.w_ready  = tgt_rsp.w_ready;
            mgr_rsp.b_resp   = tgt_rsp.b_resp;
            mgr_rsp.b_valid  = tgt_rsp.b_valid;
        end
        if (state == ST_RD) begin
            mgr_rsp.ar_ready = tgt_rsp.ar_ready;
            mgr_rsp.r_data   = tgt_rsp.r_data;
            mgr_rsp.r_resp   = tgt_rsp.r_resp;
            mgr_rsp.r_valid  = tgt_rsp.r_valid;
        end
    end

    assign b_done    = mgr_rsp.b_valid && fwd_req.b_ready;
    assign r_done    = mgr_rsp.r_valid && fwd_req.r_ready;
    assign lsu_rsp   = (grant == MGR_LSU) ? mgr_rsp : soc_pkg::axi_rsp_t'('0);
    assign fetch_rsp = (grant == MGR_FETCH) ? mgr_rsp : soc_pkg::axi_rsp_t'('0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            grant      <= MGR_LSU;
            target     <= TGT_NONE;
            err_bvalid <= 1'b0;
            err_rvalid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (pick_valid) begin
                    state  <= pick_wr ? ST_WR : ST_RD;
                    grant  <= pick_mgr;
                    target <= decode(pick_addr);     // Address stable until accepted
                end
                ST_WR:   if (b_done) state <= ST_IDLE;
                ST_RD:   if (r_done) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
            if (target == TGT_NONE && err_rsp.aw_ready) err_bvalid <= 1'b1;
            else if (err_bvalid && fwd_req.b_ready) err_bvalid <= 1'b0;
            if (target == TGT_NONE && err_rsp.ar_ready) err_rvalid <= 1'b1;
            else if (err_rvalid && fwd_req.r_ready) err_rvalid <= 1'b0;
        end
    end

endmodule

/* src/sram.sv */
`timescale 1ns/1ps

module sram #(
    parameter int unsigned SRAM_WORDS = 1024 // Power of two
) (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::axi_req_t req,
    output soc_pkg::axi_rsp_t rsp
);

    localparam int unsigned IDX_W = $clog2(SRAM_WORDS);

    logic [soc_pkg::AXI_DATA_WIDTH-1:0] mem [SRAM_WORDS]; // Word array
    logic [soc_pkg::AXI_DATA_WIDTH-1:0] rd_data;
    logic [IDX_W-1:0]                   wr_idx;
    logic [IDX_W-1:0]                   rd_idx;
    logic                               b_valid;
    logic                               r_valid;
    logic                               wr_acc;
    logic                               rd_acc;

    assign wr_idx = req.aw_addr[IDX_W+1:2];                // Wraps modulo depth
    assign rd_idx = req.ar_addr[IDX_W+1:2];
    assign wr_acc = req.aw_valid && req.w_valid && !b_valid; // Blocked while B pending
    assign rd_acc = req.ar_valid && !r_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_acc) b_valid <= 1'b1;
            else if (req.b_ready) b_valid <= 1'b0;
            if (rd_acc) r_valid <= 1'b1;
            else if (req.r_ready) r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < soc_pkg::AXI_STRB_WIDTH; i++) begin
            if (wr_acc && req.w_strb[i]) mem[wr_idx][8*i +: 8] <= req.w_data[8*i +: 8];
        end
        if (rd_acc) rd_data <= mem[rd_idx];                 // Held until next accept
    end

    always_comb begin
        rsp          = '0;
        rsp.aw_ready = wr_acc;
        rsp.w_ready  = wr_acc;
        rsp.b_resp   = soc_pkg::RESP_OKAY;
        rsp.b_valid  = b_valid;
        rsp.ar_ready = rd_acc;
        rsp.r_data   = rd_data;
        rsp.r_resp   = soc_pkg::RESP_OKAY;
        rsp.r_valid  = r_valid;
    end

endmodule

/* src/clint.sv */
`timescale 1ns/1ps

module clint (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::axi_req_t req,
    output soc_pkg::axi_rsp_t rsp
);

    logic [63:0]                        mtime;     // Free-running machine timer
    logic [63:0]                        mtime_nxt;
    logic [soc_pkg::AXI_DATA_WIDTH-1:0] rd_data;
    logic                               b_valid;
    logic                               r_valid;
    logic                               wr_acc;
    logic                               rd_acc;
    logic                               wr_hi;     // Offset 4 selects upper half
    logic                               rd_hi;

    assign wr_acc = req.aw_valid && req.w_valid && !b_valid;
    assign rd_acc = req.ar_valid && !r_valid;
    assign wr_hi  = req.aw_addr[2];
    assign rd_hi  = req.ar_addr[2];

    // Count, or overlay the strobed bytes of one half
    always_comb begin
        mtime_nxt = mtime + 64'd1;
        for (int i = 0; i < soc_pkg::AXI_STRB_WIDTH; i++) begin
            if (wr_acc && req.w_strb[i]) begin
                mtime_nxt[(wr_hi ? 32 : 0) + 8*i +: 8] = req.w_data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime   <= '0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            mtime <= mtime_nxt;                        // Written value visible next clock
            if (wr_acc) b_valid <= 1'b1;
            else if (req.b_ready) b_valid <= 1'b0;
            if (rd_acc) r_valid <= 1'b1;
            else if (req.r_ready) r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) rd_data <= rd_hi ? mtime[63:32] : mtime[31:0]; // Sampled at accept
    end

    always_comb begin
        rsp          = '0;
        rsp.aw_ready = wr_acc;
        rsp.w_ready  = wr_acc;
        rsp.b_resp   = soc_pkg::RESP_OKAY;
        rsp.b_valid  = b_valid;
        rsp.ar_ready = rd_acc;
        rsp.r_data   = rd_data;
        rsp.r_resp   = soc_pkg::RESP_OKAY;
        rsp.r_valid  = r_valid;
    end

endmodule

/* src/uart.sv */
`timescale 1ns/1ps

module uart (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::axi_req_t req,
    output soc_pkg::axi_rsp_t rsp,
    output logic [7:0]        tx_data,   // Last byte written
    output logic              tx_valid   // One-clock strobe per byte
);

    logic b_valid;
    logic r_valid;
    logic wr_acc;
    logic rd_acc;

    assign wr_acc = req.aw_valid && req.w_valid && !b_valid;
    assign rd_acc = req.ar_valid && !r_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= wr_acc && req.w_strb[0]; // Only byte lane 0 carries TX data
            if (wr_acc) b_valid <= 1'b1;
            else if (req.b_ready) b_valid <= 1'b0;
            if (rd_acc) r_valid <= 1'b1;
            else if (req.r_ready) r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc && req.w_strb[0]) tx_data <= req.w_data[7:0];
    end

    always_comb begin
        rsp          = '0;                       // Reads return zero
        rsp.aw_ready = wr_acc;
        rsp.w_ready  = wr_acc;
        rsp.b_resp   = soc_pkg::RESP_OKAY;
        rsp.b_valid  = b_valid;
        rsp.ar_ready = rd_acc;
        rsp.r_resp   = soc_pkg::RESP_OKAY;
        rsp.r_valid  = r_valid;
    end

endmodule

/* src/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
    parameter int unsigned SRAM_WORDS = 1024 // SRAM depth in words
) (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::axi_req_t fetch_req,     // Instruction fetch manager
    input  soc_pkg::axi_req_t lsu_req,       // Load/store manager
    output soc_pkg::axi_rsp_t fetch_rsp,
    output soc_pkg::axi_rsp_t lsu_rsp,
    output logic [7:0]        uart_tx_data,
    output logic              uart_tx_valid
);

    soc_pkg::axi_req_t sram_req;  // Xbar to devices
    soc_pkg::axi_req_t clint_req;
    soc_pkg::axi_req_t uart_req;
    soc_pkg::axi_rsp_t sram_rsp;  // Devices back to xbar
    soc_pkg::axi_rsp_t clint_rsp;
    soc_pkg::axi_rsp_t uart_rsp;

    axi_lite_xbar axi_lite_xbar_u0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .lsu_req   (lsu_req),
        .fetch_rsp (fetch_rsp),
        .lsu_rsp   (lsu_rsp),
        .sram_req  (sram_req),
        .sram_rsp  (sram_rsp),
        .clint_req (clint_req),
        .clint_rsp (clint_rsp),
        .uart_req  (uart_req),
        .uart_rsp  (uart_rsp)
    );

    sram #(
        .SRAM_WORDS (SRAM_WORDS)
    ) sram_u0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

    clint clint_u0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (clint_req),
        .rsp   (clint_rsp)
    );

    uart uart_u0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (uart_req),
        .rsp      (uart_rsp),
        .tx_data  (uart_tx_data),  // Straight to the pins
        .tx_valid (uart_tx_valid)
    );

endmodule

/* tb/soc_asserts.sv */
`timescale 1ns/1ps

module soc_asserts (
    input logic              clk,
    input logic              rst_n,
    input soc_pkg::axi_req_t fetch_req,
    input soc_pkg::axi_req_t lsu_req,
    input soc_pkg::axi_rsp_t fetch_rsp,
    input soc_pkg::axi_rsp_t lsu_rsp,
    input logic              uart_tx_valid
);

    int err_count = 0; // Failures so far, polled from the testbench

    // R channel and payload frozen while the manager stalls
    lsu_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rsp.r_valid && !lsu_req.r_ready |=>
        lsu_rsp.r_valid && $stable(lsu_rsp.r_data) && $stable(lsu_rsp.r_resp))
        else begin
            err_count++;
            $error("lsu R response changed while r_ready low");
        end

    fetch_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.r_valid && !fetch_req.r_ready |=>
        fetch_rsp.r_valid && $stable(fetch_rsp.r_data) && $stable(fetch_rsp.r_resp))
        else begin
            err_count++;
            $error("fetch R response changed while r_ready low");
        end

    // B channel held the same way
    lsu_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rsp.b_valid && !lsu_req.b_ready |=> lsu_rsp.b_valid && $stable(lsu_rsp.b_resp))
        else begin
            err_count++;
            $error("lsu B response changed while b_ready low");
        end

    fetch_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.b_valid && !fetch_req.b_ready |=> fetch_rsp.b_valid && $stable(fetch_rsp.b_resp))
        else begin
            err_count++;
            $error("fetch B response changed while b_ready low");
        end

    // One clock per TX byte
    tx_single: assert property (@(posedge clk) disable iff (!rst_n)
        uart_tx_valid |=> !uart_tx_valid)
        else begin
            err_count++;
            $error("uart_tx_valid high for two cycles");
        end

    // Sync reset clears every response valid
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !lsu_rsp.r_valid && !lsu_rsp.b_valid && !fetch_rsp.r_valid
                   && !fetch_rsp.b_valid && !uart_tx_valid)
        else begin
            err_count++;
            $error("valid output high after reset");
        end

endmodule

bind soc_top soc_asserts asserts_u0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req     (fetch_req),
    .lsu_req       (lsu_req),
    .fetch_rsp     (fetch_rsp),
    .lsu_rsp       (lsu_rsp),
    .uart_tx_valid (uart_tx_valid)
);

/* tb/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb;

    localparam int SRAM_WORDS = 256;          // Small depth so random addresses wrap
    localparam int TIMEOUT    = 100;          // Cycles per wait loop
    localparam int LSU        = 0;
    localparam int FETCH      = 1;

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    soc_pkg::axi_req_t mreq [2];              // Index 0 lsu, 1 fetch
    soc_pkg::axi_rsp_t mrsp [2];
    logic [7:0]        uart_tx_data;
    logic              uart_tx_valid;
    logic [63:0]       cycle = '0;            // Free-running cycle count
    int                tx_count = 0;          // UART pulses seen
    logic [7:0]        tx_byte;               // Last UART byte seen
    logic [31:0]       model [int];           // Expected SRAM words by index
    logic [31:0]       addrs [$];             // SRAM addresses written

    soc_top #(
        .SRAM_WORDS (SRAM_WORDS)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_req     (mreq[FETCH]),
        .lsu_req       (mreq[LSU]),
        .fetch_rsp     (mrsp[FETCH]),
        .lsu_rsp       (mrsp[LSU]),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid)
    );

    always #2 clk = ~clk;                     // 4 ns period

    always @(posedge clk) cycle <= cycle + 64'd1;

    always @(negedge clk) begin
        if (uart_tx_valid) begin              // Mid-cycle sample of the TX strobe
            tx_count++;
            tx_byte = uart_tx_data;
        end
        if (UUT.asserts_u0.err_count != 0) abort_run("A bound protocol assertion failed");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic value_mismatch(input string msg);
        abort_run($sformatf("[FAIL] t=%0t %s", $time, msg));
    endtask

    task automatic expect_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else value_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic expect_resp(input soc_pkg::resp_t got, input soc_pkg::resp_t exp,
                               input string what);
        assert (got === exp)
        else value_mismatch($sformatf("%s: resp %0d, expected %0d", what, got, exp));
    endtask

    function automatic bit outputs_idle();
        return !(mrsp[0].aw_ready || mrsp[0].w_ready || mrsp[0].ar_ready || mrsp[0].b_valid
              || mrsp[0].r_valid || mrsp[1].aw_ready || mrsp[1].w_ready || mrsp[1].ar_ready
              || mrsp[1].b_valid || mrsp[1].r_valid || uart_tx_valid);
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return (addr >> 2) % SRAM_WORDS;      // SRAM wraps modulo depth
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    // One write or read on manager m, response held off for hold cycles
    task automatic xfer(input int m, input bit wr, input logic [31:0] addr,
                        input logic [31:0] data, input logic [3:0] strb, input int hold,
                        output logic [31:0] rdata, output soc_pkg::resp_t resp);
        int n;
        @(posedge clk);
        #1;
        mreq[m].aw_addr  = addr;
        mreq[m].ar_addr  = addr;
        mreq[m].w_data   = data;
        mreq[m].w_strb   = strb;
        mreq[m].aw_valid = wr;                // AW and W together
        mreq[m].w_valid  = wr;
        mreq[m].ar_valid = !wr;
        n = 0;
        @(negedge clk);
        while (!(wr ? mrsp[m].aw_ready : mrsp[m].ar_ready)) begin
            n++;
            if (n > TIMEOUT) abort_run("Timeout waiting for request acceptance");
            @(negedge clk);
        end
        assert (!wr || mrsp[m].w_ready) else value_mismatch("w_ready not with aw_ready");
        @(posedge clk);                       // Handshake edge
        #1;
        mreq[m].aw_valid = 1'b0;
        mreq[m].w_valid  = 1'b0;
        mreq[m].ar_valid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!(wr ? mrsp[m].b_valid : mrsp[m].r_valid)) begin
            n++;
            if (n > TIMEOUT) abort_run("Timeout waiting for response valid");
            @(negedge clk);
        end
        assert (n == 0) else value_mismatch($sformatf("response %0d cycles late", n));
        repeat (hold + 1) @(posedge clk);     // Back-pressure window
        #1;
        mreq[m].b_ready = wr;
        mreq[m].r_ready = !wr;
        @(negedge clk);
        assert (wr ? mrsp[m].b_valid : mrsp[m].r_valid)
        else value_mismatch("response dropped before ready");
        rdata = wr ? 32'd0 : mrsp[m].r_data;
        resp  = wr ? mrsp[m].b_resp : mrsp[m].r_resp;
        @(posedge clk);
        #1;
        mreq[m].b_ready = 1'b0;
        mreq[m].r_ready = 1'b0;
    endtask

    initial begin
        logic [31:0]    addr;
        logic [31:0]    data;
        logic [31:0]    rd;
        logic [31:0]    rd_b;
        logic [31:0]    v;
        logic [63:0]    t0;
        soc_pkg::resp_t resp;
        soc_pkg::resp_t resp_b;
        int             tx_seen;
        int             hold_a;
        int             hold_b;
        void'($urandom(32'h149b));
        mreq[LSU]   = '0;
        mreq[FETCH] = '0;
        repeat (7) begin                      // Reset spans 8 rising edges
            @(negedge clk);
            assert (outputs_idle()) else value_mismatch("valid or ready high in reset");
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (outputs_idle()) else value_mismatch("valid or ready high after reset");

        for (int i = 0; i < 8; i++) begin     // Full-word writes through lsu
            addr = soc_pkg::SRAM_BASE | ($urandom & 32'h0FFF_FFFC);
            data = $urandom;
            xfer(LSU, 1'b1, addr, data, 4'hF, $urandom % 3, rd, resp);
            expect_resp(resp, soc_pkg::RESP_OKAY, "SRAM write");
            model[word_index(addr)] = data;
            addrs.push_back(addr);
        end
        data = $urandom;                      // Partial strobe through fetch, B held off
        xfer(FETCH, 1'b1, addrs[2], data, 4'b0110, 2, rd, resp);
        expect_resp(resp, soc_pkg::RESP_OKAY, "SRAM partial write");
        model[word_index(addrs[2])] = merge_bytes(model[word_index(addrs[2])], data, 4'b0110);
        foreach (addrs[k]) begin              // Read back through fetch
            xfer(FETCH, 1'b0, addrs[k], '0, '0, $urandom % 4, rd, resp);
            expect_word(rd, model[word_index(addrs[k])], "SRAM readback");
            expect_resp(resp, soc_pkg::RESP_OKAY, "SRAM read");
        end

        tx_seen = tx_count;
        data    = $urandom;
        xfer(LSU, 1'b1, soc_pkg::UART_BASE, data, 4'hF, 1, rd, resp);
        expect_resp(resp, soc_pkg::RESP_OKAY, "UART write");
        assert (tx_count == tx_seen + 1)
        else value_mismatch($sformatf("%0d UART pulses, expected 1", tx_count - tx_seen));
        expect_word({24'd0, tx_byte}, {24'd0, data[7:0]}, "UART byte");

        v  = $urandom & 32'h7FFF_FFFF;        // No low-word wrap during the test
        t0 = cycle;
        xfer(LSU, 1'b1, soc_pkg::CLINT_BASE, v, 4'hF, 0, rd, resp);
        xfer(LSU, 1'b1, soc_pkg::CLINT_BASE + 32'd4, 32'd0, 4'hF, 0, rd, resp);
        xfer(FETCH, 1'b0, soc_pkg::CLINT_BASE, '0, '0, 0, rd, resp);
        expect_resp(resp, soc_pkg::RESP_OKAY, "timer read");
        assert (rd >= v && {32'd0, rd} < {32'd0, v} + (cycle - t0))
        else value_mismatch($sformatf("timer %h outside [%h, +%0d)", rd, v, cycle - t0));
        xfer(LSU, 1'b0, soc_pkg::CLINT_BASE, '0, '0, 2, rd_b, resp);
        assert (rd_b > rd) else value_mismatch($sformatf("timer %h not above %h", rd_b, rd));

        xfer(FETCH, 1'b0, 32'h4000_0000, '0, '0, 3, rd, resp); // Hole in the map
        expect_resp(resp, soc_pkg::RESP_DECERR, "unmapped read");
        expect_word(rd, 32'd0, "unmapped read data");
        xfer(LSU, 1'b1, 32'h4000_0010, $urandom, 4'hF, 2, rd, resp);
        expect_resp(resp, soc_pkg::RESP_DECERR, "unmapped write");

        hold_a = $urandom % 8;
        hold_b = $urandom % 8;
        fork                                  // Both managers in the same cycle
            xfer(LSU, 1'b0, addrs[0], '0, '0, hold_a, rd, resp);
            xfer(FETCH, 1'b0, addrs[1], '0, '0, hold_b, rd_b, resp_b);
        join
        expect_word(rd, model[word_index(addrs[0])], "contended lsu read");
        expect_word(rd_b, model[word_index(addrs[1])], "contended fetch read");
        expect_resp(resp, soc_pkg::RESP_OKAY, "contended lsu read");
        expect_resp(resp_b, soc_pkg::RESP_OKAY, "contended fetch read");

        @(negedge clk);
        if (UUT.asserts_u0.err_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("A bound protocol assertion failed");
        end
    end

endmodule

/* soc_top.f */
src/soc_pkg.sv
src/axi_lite_xbar.sv
src/sram.sv
src/clint.sv
src/uart.sv
src/soc_top.sv
tb/soc_asserts.sv
tb/soc_tb.sv

/* Makefile */
FLIST := soc_top.f
LOG   := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module soc_tb -f $(FLIST)

sim:
	verilator --binary --assert --top-module soc_tb -f $(FLIST) -Mdir obj_dir -o soc_sim
	./obj_dir/soc_sim | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
